//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = credit_counter_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo '*** FAILED ***' >> $(LOG)
	cat $(LOG)
	! grep -q '\*\*\* FAILED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- credit_counter.sv
//##############################
// credit block of a VC router, top level
// P grant decoders, one tracker,
// one full mask per input VC
// grants, credits and allocations are
// one-cycle pulses, no back-pressure
//##############################

`timescale 1ns/1ns
`default_nettype none

`include "credit_params.svh"

module credit_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  credit_pkg::all_vc_t     flit_is_tail_i,
    input  credit_pkg::all_vc_t     ovc_is_assigned_i,
    input  credit_pkg::all_vc_t     granted_ivc_i,
    input  credit_pkg::all_vc_t     ivc_getting_sw_grant_i,
    input  credit_pkg::all_vc_t     credit_in_i,
    input  credit_pkg::all_vc_t     ovc_allocated_i,
    input  credit_pkg::vc_vec_t     assigned_ovc_num_i [`CC_NUM_PORT*`CC_NUM_VC],
    input  credit_pkg::other_port_t granted_dest_port_i [`CC_NUM_PORT],
    input  credit_pkg::other_port_t dest_port_i [`CC_NUM_PORT*`CC_NUM_VC],
    output credit_pkg::all_vc_t     ovc_available_o,
    output credit_pkg::all_vc_t     assigned_ovc_not_full_o
);

    localparam int P  = `CC_NUM_PORT;
    localparam int V  = `CC_NUM_VC;
    localparam int PV = P * V;

    credit_pkg::other_vc_t dec_by_src [P]; // indexed by source port
    credit_pkg::other_vc_t rel_by_src [P];
    credit_pkg::all_vc_t   credit_decreased_all;
    credit_pkg::all_vc_t   ovc_released_all;
    credit_pkg::all_vc_t   full_all;
    credit_pkg::all_vc_t   nearly_full_all;
    credit_pkg::all_vc_t   assigned_ovc_is_full;

    for (genvar p = 0; p < P; p++) begin : g_port
        credit_pkg::vc_vec_t   port_ovc_num [V];
        credit_pkg::other_vc_t full_view;
        credit_pkg::other_vc_t nearly_full_view;
        credit_pkg::other_vc_t credit_in_view;

        always_comb begin
            for (int v = 0; v < V; v++) begin
                port_ovc_num[v] = assigned_ovc_num_i[p*V + v];
            end
            for (int q = 0; q < P - 1; q++) begin // skip own port
                full_view[q*V +: V]        = full_all[(q < p ? q : q + 1)*V +: V];
                nearly_full_view[q*V +: V] = nearly_full_all[(q < p ? q : q + 1)*V +: V];
                credit_in_view[q*V +: V]   = credit_in_i[(q < p ? q : q + 1)*V +: V];
            end
        end

        grant_decoder #(.PORT(p)) u_dec (
            .flit_is_tail_i      (flit_is_tail_i[p*V +: V]),
            .assigned_ovc_num_i  (port_ovc_num),
            .ovc_is_assigned_i   (ovc_is_assigned_i[p*V +: V]),
            .granted_dest_port_i (granted_dest_port_i[p]),
            .granted_ivc_i       (granted_ivc_i[p*V +: V]),
            .credit_decreased_o  (dec_by_src[p]),
            .ovc_released_o      (rel_by_src[p])
        );

        for (genvar v = 0; v < V; v++) begin : g_ivc
            full_mask_gen u_mask (
                .clk                    (clk),
                .reset                  (reset),
                .assigned_ovc_num_i     (assigned_ovc_num_i[p*V + v]),
                .dest_port_i            (dest_port_i[p*V + v]),
                .full_i                 (full_view),
                .nearly_full_i          (nearly_full_view),
                .credit_in_i            (credit_in_view),
                .ivc_getting_sw_grant_i (ivc_getting_sw_grant_i[p*V + v]),
                .assigned_ovc_is_full_o (assigned_ovc_is_full[p*V + v])
            );
        end
    end

    // gather decoder slots back into router-wide order
    always_comb begin
        int o;
        int q;
        credit_decreased_all = ovc_allocated_i; // header leaves on allocation
        ovc_released_all     = '0;
        for (int k = 0; k < PV; k++) begin
            o = k / V;
            for (int s = 0; s < P; s++) begin
                if (s != o) begin
                    q = (o < s) ? o : o - 1; // slot of port o seen from port s
                    credit_decreased_all[k] = credit_decreased_all[k] | dec_by_src[s][q*V + k%V];
                    ovc_released_all[k]     = ovc_released_all[k] | rel_by_src[s][q*V + k%V];
                end
            end
        end
    end

    credit_tracker u_tracker (
        .clk                (clk),
        .reset              (reset),
        .credit_in_i        (credit_in_i),
        .credit_decreased_i (credit_decreased_all),
        .ovc_released_i     (ovc_released_all),
        .ovc_allocated_i    (ovc_allocated_i),
        .full_o             (full_all),
        .nearly_full_o      (nearly_full_all),
        .ovc_available_o    (ovc_available_o)
    );

    assign assigned_ovc_not_full_o = ~assigned_ovc_is_full;

endmodule

`default_nettype wire

//--- credit_counter_tb.sv
//##############################
// directed tests for the credit block
// inputs change on the falling edge
// a model tracks counts and VC status
// each test frees and refills the VC it used
//##############################

`timescale 1ns/1ns
`default_nettype none

`include "credit_params.svh"

module credit_counter_tb;

    localparam int P  = `CC_NUM_PORT;
    localparam int V  = `CC_NUM_VC;
    localparam int B  = `CC_BUF_DEPTH;
    localparam int PV = P * V;
    localparam int TEST_CYCLES = 8 + 2 + 24 + 24 + 24 + 24; // reset plus a budget per test
    localparam int WATCHDOG_NS = TEST_CYCLES * 4 + 400;

    logic clk;
    logic reset;
    credit_pkg::all_vc_t     flit_is_tail, ovc_is_assigned, granted_ivc;
    credit_pkg::all_vc_t     ivc_getting_sw_grant, credit_in, ovc_allocated;
    credit_pkg::vc_vec_t     assigned_ovc_num [PV];
    credit_pkg::other_port_t granted_dest_port [P];
    credit_pkg::other_port_t dest_port [PV];
    credit_pkg::all_vc_t     ovc_available;
    credit_pkg::all_vc_t     assigned_ovc_not_full;

    int                  model_count [PV]; // expected credits per output VC
    credit_pkg::all_vc_t model_status;     // 1 = allocated
    credit_pkg::all_vc_t dec_pend;         // grants driven this cycle
    credit_pkg::all_vc_t rel_pend;
    logic [31:0]         lfsr_state;
    int                  errors;
    int                  checks;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    credit_counter credit_counter_inst (
        .clk                     (clk),
        .reset                   (reset),
        .flit_is_tail_i          (flit_is_tail),
        .ovc_is_assigned_i       (ovc_is_assigned),
        .granted_ivc_i           (granted_ivc),
        .ivc_getting_sw_grant_i  (ivc_getting_sw_grant),
        .credit_in_i             (credit_in),
        .ovc_allocated_i         (ovc_allocated),
        .assigned_ovc_num_i      (assigned_ovc_num),
        .granted_dest_port_i     (granted_dest_port),
        .dest_port_i             (dest_port),
        .ovc_available_o         (ovc_available),
        .assigned_ovc_not_full_o (assigned_ovc_not_full)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois taps 32 22 2 1
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // one step per bit
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    // index of port dst among the other ports seen from port src
    function automatic int slot_of(input int src, input int dst);
        return (dst < src) ? dst : dst - 1;
    endfunction

    task automatic check_vec(input string name, input credit_pkg::all_vc_t exp,
                             input credit_pkg::all_vc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic pick_route(output int s, output int sv, output int o, output int ov);
        o  = rand_bits(8) % P;
        ov = rand_bits(8) % V;
        s  = (o + 1 + rand_bits(8) % (P - 1)) % P; // any port but o
        sv = rand_bits(8) % V;
    endtask

    // switch grant from input VC (s,sv) toward output VC (o,ov)
    task automatic send_grant(input int s, input int sv, input int o, input int ov,
                              input logic tail);
        int i;
        i = s * V + sv;
        ovc_is_assigned[i]      = 1'b1;
        assigned_ovc_num[i]     = credit_pkg::vc_vec_t'(1 << ov);
        granted_ivc[i]          = 1'b1;
        granted_dest_port[s]    = credit_pkg::other_port_t'(1 << slot_of(s, o));
        flit_is_tail[i]         = tail;
        ivc_getting_sw_grant[i] = 1'b1;
        dec_pend[o * V + ov]    = 1'b1;
        rel_pend[o * V + ov]    = tail;
    endtask

    // one clock of model update, edge, pulse clearing and availability check
    task automatic tick(input string name);
        credit_pkg::all_vc_t exp;
        logic                dec;
        for (int k = 0; k < PV; k++) begin
            dec = dec_pend[k] | ovc_allocated[k]; // header leaves on allocation
            if (credit_in[k] && !dec) begin
                model_count[k]++;
            end else if (!credit_in[k] && dec) begin
                model_count[k]--;
            end
            if (rel_pend[k]) begin
                model_status[k] = 1'b0;
            end
            if (ovc_allocated[k]) begin
                model_status[k] = 1'b1;
            end
        end
        @(posedge clk);
        @(negedge clk);
        granted_ivc          = '0;
        flit_is_tail         = '0;
        ivc_getting_sw_grant = '0;
        credit_in            = '0;
        ovc_allocated        = '0;
        dec_pend             = '0;
        rel_pend             = '0;
        for (int p = 0; p < P; p++) begin
            granted_dest_port[p] = '0;
        end
        for (int k = 0; k < PV; k++) begin
            exp[k] = !model_status[k] && (model_count[k] > 1); // free with two flits of room
        end
        check_vec(name, exp, ovc_available);
    endtask

    // release with a tail grant, then give back every credit
    task automatic free_vc(input int o, input int ov, input string name);
        send_grant((o + 1) % P, 0, o, ov, 1'b1);
        credit_in[o * V + ov] = 1'b1; // cancels the tail's decrement
        tick(name);
        while (model_count[o * V + ov] < B) begin
            credit_in[o * V + ov] = 1'b1;
            tick(name);
        end
    endtask

    task automatic test_reset_state();
        check_vec("reset_state", '1, ovc_available);
        check_vec("reset_state", '1, assigned_ovc_not_full);
    endtask

    task automatic test_alloc_release();
        int s, sv, o, ov, k;
        pick_route(s, sv, o, ov);
        k = o * V + ov;
        ovc_allocated[k] = 1'b1;
        tick("alloc_release");
        check_bit("alloc_release", 1'b0, ovc_available[k]);
        send_grant(s, sv, o, ov, 1'b1);
        tick("alloc_release");
        check_bit("alloc_release", 1'b1, ovc_available[k]); // free with two credits left
        send_grant(s, sv, o, ov, 1'b1);
        ovc_allocated[k] = 1'b1;
        credit_in[k]     = 1'b1; // count stays at two
        tick("alloc_release");
        check_bit("alloc_release", 1'b0, ovc_available[k]);
        free_vc(o, ov, "alloc_release");
    endtask

    task automatic test_credit_drain();
        int s, sv, o, ov, k;
        pick_route(s, sv, o, ov);
        k = o * V + ov;
        ovc_allocated[k] = 1'b1;
        tick("credit_drain");
        repeat (B - 2) begin
            send_grant(s, sv, o, ov, 1'b0);
            tick("credit_drain");
        end
        check_bit("credit_drain", 1'b0, ovc_available[k]);
        send_grant(s, sv, o, ov, 1'b1);
        credit_in[k] = 1'b1;
        tick("credit_drain");
        check_bit("credit_drain", 1'b0, ovc_available[k]); // released but nearly full
        credit_in[k] = 1'b1;
        tick("credit_drain");
        check_bit("credit_drain", 1'b1, ovc_available[k]);
        free_vc(o, ov, "credit_drain");
    endtask

    task automatic test_credit_balance();
        int s, sv, o, ov, k;
        pick_route(s, sv, o, ov);
        k = o * V + ov;
        send_grant(s, sv, o, ov, 1'b0);
        tick("credit_balance");
        repeat (6) begin
            send_grant(s, sv, o, ov, 1'b0);
            credit_in[k] = 1'b1;
            tick("credit_balance");
            check_bit("credit_balance", 1'b1, ovc_available[k]);
        end
        free_vc(o, ov, "credit_balance");
    endtask

    task automatic test_full_mask();
        int s, sv, o, ov, k, i;
        pick_route(s, sv, o, ov);
        k = o * V + ov;
        i = s * V + sv;
        ovc_is_assigned[i]  = 1'b1;
        assigned_ovc_num[i] = credit_pkg::vc_vec_t'(1 << ov);
        dest_port[i]        = credit_pkg::other_port_t'(1 << slot_of(s, o));
        tick("full_mask");
        check_bit("full_mask", 1'b1, assigned_ovc_not_full[i]);
        ovc_allocated[k] = 1'b1;
        tick("full_mask");
        repeat (B - 1) begin
            send_grant(s, sv, o, ov, 1'b0);
            tick("full_mask");
        end
        check_bit("full_mask", 1'b0, assigned_ovc_not_full[i]); // last credit spent by own grant
        tick("full_mask"); // mask registers the full flag
        check_bit("full_mask", 1'b0, assigned_ovc_not_full[i]);
        credit_in[k] = 1'b1;
        tick("full_mask");
        check_bit("full_mask", 1'b1, assigned_ovc_not_full[i]);
        free_vc(o, ov, "full_mask");
    endtask

    initial begin
        errors               = 0;
        checks               = 0;
        lfsr_state           = 32'h117f;
        flit_is_tail         = '0;
        ovc_is_assigned      = '0;
        granted_ivc          = '0;
        ivc_getting_sw_grant = '0;
        credit_in            = '0;
        ovc_allocated        = '0;
        model_status         = '0;
        dec_pend             = '0;
        rel_pend             = '0;
        for (int k = 0; k < PV; k++) begin
            assigned_ovc_num[k] = '0;
            dest_port[k]        = '0;
            model_count[k]      = B;
        end
        for (int p = 0; p < P; p++) begin
            granted_dest_port[p] = '0;
        end
        @(negedge reset);
        test_reset_state();
        test_alloc_release();
        test_credit_drain();
        test_credit_balance();
        test_full_mask();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- credit_params.svh
//##############################
// router size for the credit block
// every port has the same VC count and
// every output VC the same buffer depth
// CC_NUM_PORT must be at least 2
// CC_BUF_DEPTH of 1 leaves a VC nearly full at once
//##############################

`ifndef CREDIT_PARAMS_SVH
`define CREDIT_PARAMS_SVH

// router ports P
`define CC_NUM_PORT 5

// VCs per port V
`define CC_NUM_VC 4

// flits of downstream buffer per output VC B
`define CC_BUF_DEPTH 4

`endif

//--- credit_pkg.sv
//##############################
// vector and counter types of the credit block
// widths follow credit_params.svh
// other_* types leave out the source port
// and keep the remaining ports in ascending order
//##############################

`default_nettype none

`include "credit_params.svh"

package credit_pkg;

    // one bit per VC of a single port
    typedef logic [`CC_NUM_VC-1:0] vc_vec_t;

    // one-hot choice among the P-1 ports other than the source
    typedef logic [`CC_NUM_PORT-2:0] other_port_t;

    // V bits per other port, source port skipped
    typedef logic [`CC_NUM_VC*(`CC_NUM_PORT-1)-1:0] other_vc_t;

    // port p owns bits p*V to p*V+V-1
    typedef logic [`CC_NUM_PORT*`CC_NUM_VC-1:0] all_vc_t;

    // counts 0 to B inclusive
    typedef logic [$clog2(`CC_BUF_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- credit_tracker.sv
//##############################
// one credit counter per output VC
// flags are registered from the next count,
// so they match the counter right after the edge
// credit_in and decrement together cancel
// allocation wins over release in the same cycle
// overflow and underflow are errors and never clamped
//##############################

`timescale 1ns/1ns
`default_nettype none

`include "credit_params.svh"

module credit_tracker (
    input  logic                clk,
    input  logic                reset,
    input  credit_pkg::all_vc_t credit_in_i,
    input  credit_pkg::all_vc_t credit_decreased_i,
    input  credit_pkg::all_vc_t ovc_released_i,
    input  credit_pkg::all_vc_t ovc_allocated_i,
    output credit_pkg::all_vc_t full_o,
    output credit_pkg::all_vc_t nearly_full_o,
    output credit_pkg::all_vc_t ovc_available_o
);

    localparam int PV = `CC_NUM_PORT * `CC_NUM_VC;
    localparam credit_pkg::credit_t B_MAX = credit_pkg::credit_t'(`CC_BUF_DEPTH);

    credit_pkg::credit_t count_q [PV];
    credit_pkg::credit_t count_d [PV];
    credit_pkg::all_vc_t full_q;
    credit_pkg::all_vc_t nearly_full_q;
    credit_pkg::all_vc_t status_q; // 1 = output VC allocated

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            count_d[k] = count_q[k];
            if (credit_in_i[k] && !credit_decreased_i[k]) begin
                count_d[k] = count_q[k] + 1'b1;
            end else if (!credit_in_i[k] && credit_decreased_i[k]) begin
                count_d[k] = count_q[k] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < PV; k++) begin
                count_q[k] <= B_MAX; // downstream buffers start empty
            end
            full_q        <= '0;
            nearly_full_q <= '0;
            status_q      <= '0;
        end else begin
            for (int k = 0; k < PV; k++) begin
                count_q[k]       <= count_d[k];
                full_q[k]        <= (count_d[k] == '0);
                nearly_full_q[k] <= (count_d[k] <= credit_pkg::credit_t'(1));
                if (ovc_released_i[k]) begin
                    status_q[k] <= 1'b0;
                end
                if (ovc_allocated_i[k]) begin
                    status_q[k] <= 1'b1; // set after clear so allocation wins
                end
            end
        end
    end

    assign full_o        = full_q;
    assign nearly_full_o = nearly_full_q;

    // non-atomic reuse needs a free VC with room for two flits
    assign ovc_available_o = ~(status_q | nearly_full_q);

    // a returned credit must have been spent earlier, and a spent one must exist
    for (genvar k = 0; k < PV; k++) begin : g_chk
        a_no_overflow : assert property (@(posedge clk) disable iff (reset)
            !(credit_in_i[k] && !credit_decreased_i[k] && count_q[k] == B_MAX))
            else $error("credit_tracker: credit returned to full VC %0d", k);

        a_no_underflow : assert property (@(posedge clk) disable iff (reset)
            !(credit_decreased_i[k] && !credit_in_i[k] && count_q[k] == '0))
            else $error("credit_tracker: flit sent to VC %0d with no credit", k);
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
credit_pkg.sv
one_hot_mux.sv
grant_decoder.sv
credit_tracker.sv
full_mask_gen.sv
credit_counter.sv
tb_clock_gen.sv
credit_counter_tb.sv

//--- full_mask_gen.sv
//##############################
// per input VC flag that its assigned
// output VC cannot take another flit
// registered, so it lags the flags by one cycle
// a credit arriving this cycle clears the flag
//##############################

`timescale 1ns/1ns
`default_nettype none

`include "credit_params.svh"

module full_mask_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  credit_pkg::vc_vec_t     assigned_ovc_num_i,
    input  credit_pkg::other_port_t dest_port_i,
    input  credit_pkg::other_vc_t   full_i,
    input  credit_pkg::other_vc_t   nearly_full_i,
    input  credit_pkg::other_vc_t   credit_in_i,
    input  logic                    ivc_getting_sw_grant_i,
    output logic                    assigned_ovc_is_full_o
);

    localparam int V  = `CC_NUM_VC;
    localparam int P1 = `CC_NUM_PORT - 1;

    credit_pkg::other_vc_t full_masked;
    credit_pkg::other_vc_t nearly_full_masked;
    credit_pkg::vc_vec_t   full_by_port [P1];
    credit_pkg::vc_vec_t   nearly_full_by_port [P1];
    credit_pkg::vc_vec_t   full_dest;
    credit_pkg::vc_vec_t   nearly_full_dest;
    logic                  full_bits [V];
    logic                  nearly_full_bits [V];
    logic                  full_sel;
    logic                  nearly_full_sel;
    logic                  full_q;
    logic                  last_credit_q; // last credit spent by our own grant

    assign full_masked        = full_i & ~credit_in_i;
    assign nearly_full_masked = nearly_full_i & ~credit_in_i;

    always_comb begin
        for (int q = 0; q < P1; q++) begin
            full_by_port[q]        = full_masked[q*V +: V];
            nearly_full_by_port[q] = nearly_full_masked[q*V +: V];
        end
        for (int v = 0; v < V; v++) begin
            full_bits[v]        = full_dest[v];
            nearly_full_bits[v] = nearly_full_dest[v];
        end
    end

    one_hot_mux #(.payload_t(credit_pkg::vc_vec_t), .N(P1)) u_full_port_mux (
        .mux_in_i (full_by_port), .sel_i (dest_port_i), .mux_out_o (full_dest)
    );

    one_hot_mux #(.payload_t(credit_pkg::vc_vec_t), .N(P1)) u_nfull_port_mux (
        .mux_in_i (nearly_full_by_port), .sel_i (dest_port_i), .mux_out_o (nearly_full_dest)
    );

    one_hot_mux #(.payload_t(logic), .N(V)) u_full_vc_mux (
        .mux_in_i (full_bits), .sel_i (assigned_ovc_num_i), .mux_out_o (full_sel)
    );

    one_hot_mux #(.payload_t(logic), .N(V)) u_nfull_vc_mux (
        .mux_in_i (nearly_full_bits), .sel_i (assigned_ovc_num_i), .mux_out_o (nearly_full_sel)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_q        <= 1'b0;
            last_credit_q <= 1'b0;
        end else begin
            full_q        <= full_sel;
            last_credit_q <= nearly_full_sel & ivc_getting_sw_grant_i;
        end
    end

    assign assigned_ovc_is_full_o = full_q | last_credit_q;

endmodule

`default_nettype wire

//--- grant_decoder.sv
//##############################
// decodes one input port's switch grant
// into credit decrement and VC release pulses
// outputs are combinational, one cycle wide
// a grant to an unassigned input VC is dropped
//##############################

`timescale 1ns/1ns
`default_nettype none

`include "credit_params.svh"

module grant_decoder #(
    parameter int PORT = 0
) (
    input  credit_pkg::vc_vec_t     flit_is_tail_i,
    input  credit_pkg::vc_vec_t     assigned_ovc_num_i [`CC_NUM_VC],
    input  credit_pkg::vc_vec_t     ovc_is_assigned_i,
    input  credit_pkg::other_port_t granted_dest_port_i,
    input  credit_pkg::vc_vec_t     granted_ivc_i,
    output credit_pkg::other_vc_t   credit_decreased_o,
    output credit_pkg::other_vc_t   ovc_released_o
);

    localparam int V = `CC_NUM_VC;
    localparam int P = `CC_NUM_PORT;

    credit_pkg::vc_vec_t ovc_num_masked [V];
    logic                tail_bits [V];
    credit_pkg::vc_vec_t granted_ovc;
    logic                granted_tail;

    always_comb begin
        for (int v = 0; v < V; v++) begin
            ovc_num_masked[v] = ovc_is_assigned_i[v] ? assigned_ovc_num_i[v] : '0;
            tail_bits[v]      = flit_is_tail_i[v];
        end
    end

    // output VC held by the granted input VC
    one_hot_mux #(
        .payload_t (credit_pkg::vc_vec_t),
        .N         (V)
    ) u_ovc_mux (
        .mux_in_i  (ovc_num_masked),
        .sel_i     (granted_ivc_i),
        .mux_out_o (granted_ovc)
    );

    // is the leaving flit a tail
    one_hot_mux #(
        .payload_t (logic),
        .N         (V)
    ) u_tail_mux (
        .mux_in_i  (tail_bits),
        .sel_i     (granted_ivc_i),
        .mux_out_o (granted_tail)
    );

    // place the VC number in the slot of the destination port
    always_comb begin
        credit_decreased_o = '0;
        for (int q = 0; q < P - 1; q++) begin
            if (granted_dest_port_i[q]) begin
                credit_decreased_o[q*V +: V] = granted_ovc;
            end
        end
    end

    assign ovc_released_o = granted_tail ? credit_decreased_o : '0; // tail frees the VC

    // the VC allocator must have assigned an output VC before the switch grant
    always_comb begin
        assert ((granted_ivc_i & ~ovc_is_assigned_i) == '0)
            else $error("grant_decoder port %0d: grant %b hits unassigned VC (assigned %b)",
                        PORT, granted_ivc_i, ovc_is_assigned_i);
    end

endmodule

`default_nettype wire

//--- one_hot_mux.sv
//##############################
// AND-OR mux with a one-hot select
// an all-zero select gives an all-zero output
// payload_t must be a packed type
//##############################

`timescale 1ns/1ns
`default_nettype none

module one_hot_mux #(
    parameter type payload_t = logic,
    parameter int  N         = 4
) (
    input  payload_t       mux_in_i [N],
    input  logic [N-1:0]   sel_i,
    output payload_t       mux_out_o
);

    always_comb begin
        mux_out_o = '0;
        for (int n = 0; n < N; n++) begin
            if (sel_i[n]) begin
                mux_out_o = payload_t'(mux_out_o | mux_in_i[n]); // selected lanes ORed
            end
        end
    end

    // two set bits would merge two payloads into garbage
    always_comb begin
        assert ($onehot0(sel_i))
            else $error("one_hot_mux: select %b is not one-hot", sel_i);
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
//##############################
// testbench clock and reset
// 4 ns clock period
// reset held high for 8 clock cycles,
// released on a falling edge
//##############################

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o); // away from the sampling edge
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire
